// ==== rca.f ====
hw/rca_cpu_pkg.sv
hw/rca_config_pkg.sv
hw/rca_config_regs.sv
hw/rca_operand_router.sv
hw/rca_tile.sv
hw/rca_result_collector.sv
hw/rca_wrapper.sv
verification/rca_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then check the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module rca_tb \
    -f rca.f -o rca_sim > build.log 2>&1 \
    && ./obj_dir/rca_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0

// ==== verification/rca_tb.sv ====
`timescale 1ns/1ps

module rca_tb;

    import rca_cpu_pkg::*;
    import rca_config_pkg::*;

    localparam int num_tiles = 4;
    // six tests need about 600 cycles.
    localparam int max_cycles = 2000;

    logic                clk = 1'b0;
    logic                rst_n = 1'b0;
    rca_cfg_write_t      cfg = '0;
    logic                lock = 1'b0;
    logic                unlock = 1'b0;
    logic                config_locked;
    rca_issue_t          issue = '0;
    logic                ready;
    logic                done;
    rca_wb_t             wb;
    logic                ack = 1'b0;

    rca_wb_t             exp_q[$];
    rca_wb_t             exp_head = '0;
    rca_wb_t             wb_prev = '0;
    logic                hold_prev = 1'b0;
    int                  outstanding = 0;
    int                  m_op[num_tiles];
    int                  m_src_a[num_tiles];
    int                  m_src_b[num_tiles];
    int                  m_map[num_srcs];
    logic                model_locked = 1'b0;
    int                  ack_mode = 0;
    logic [id_width-1:0] next_id = '0;
    int                  errors = 0;
    int                  errors_seen = 0;
    int                  passes = 0;
    int                  fails = 0;
    int                  cycle_count = 0;
    int                  accepted;

    rca_wrapper #(
        .num_tiles(num_tiles)
    ) i_rca_wrapper (
        .clk, .rst_n, .cfg, .lock, .unlock, .config_locked,
        .issue, .ready, .done, .wb, .ack
    );

    always #20 clk = ~clk;

    // ########################################
    // reference model.
    // ########################################

    function automatic rca_wb_t expected_wb(input rca_operands_t ops, input logic [3:0] req_id);
        logic [xlen-1:0] rs [num_srcs];
        logic [xlen-1:0] outs [num_tiles];
        logic [xlen-1:0] prev;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        rca_wb_t         w;
        rs = '{ops.rs1, ops.rs2, ops.rs3, ops.rs4, ops.rs5};
        prev = '0;
        for (int t = 0; t < num_tiles; t++) begin
            a = (m_src_a[t] == 5) ? prev : rs[m_src_a[t]];
            b = (m_src_b[t] == 5) ? prev : rs[m_src_b[t]];
            case (m_op[t])
                0: outs[t] = a + b;
                1: outs[t] = a - b;
                2: outs[t] = a & b;
                3: outs[t] = a | b;
                4: outs[t] = a ^ b;
                5: outs[t] = a << b[4:0];
                6: outs[t] = a >> b[4:0];
                default: outs[t] = a;
            endcase
            prev = outs[t];
        end
        w.id = req_id;
        w.results = {outs[m_map[0]], outs[m_map[1]], outs[m_map[2]], outs[m_map[3]],
                     outs[m_map[4]]};
        return w;
    endfunction

    always @(posedge clk) begin
        if (rst_n) begin
            if (done && ack) begin
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("a result came back at %0t ns with no request outstanding", $time);
                end
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                end
            end
            if (issue.new_request && ready) begin
                exp_q.push_back(expected_wb(issue.operands, issue.id));
            end
            exp_head <= (exp_q.size() != 0) ? exp_q[0] : '0;
            outstanding <= exp_q.size();
        end
        hold_prev <= done && !ack;
        wb_prev <= wb;
    end

    always @(posedge clk) begin
        case (ack_mode)
            1: ack <= 1'b1;
            2: ack <= 1'($urandom_range(1, 0));
            default: ack <= 1'b0;
        endcase
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ########################################
    // checks.
    // ########################################

    assert property (@(posedge clk) disable iff (!rst_n) (done && ack) |-> (wb == exp_head))
    else begin
        errors++;
        $display("MISMATCH at %0t ns: wb expected %h, got %h", $time, $sampled(exp_head),
                 $sampled(wb));
    end

    assert property (@(posedge clk) disable iff (!rst_n) !config_locked |-> !ready)
    else begin
        errors++;
        $display("ready was high at %0t ns while the configuration was unlocked", $time);
    end

    assert property (@(posedge clk) disable iff (!rst_n) (outstanding >= 4) |-> !ready)
    else begin
        errors++;
        $display("ready was high at %0t ns with four requests outstanding", $time);
    end

    // head entry must hold until acked.
    assert property (@(posedge clk) disable iff (!rst_n) hold_prev |-> (done && wb == wb_prev))
    else begin
        errors++;
        $display("done or wb changed at %0t ns before the core acked", $time);
    end

    task automatic expect_value(input string name, input int actual, input int expected);
        assert (actual == expected) else begin
            errors++;
            $display("MISMATCH at %0t ns: %s expected %0d, got %0d", $time, name, expected,
                     actual);
        end
    endtask

    // ########################################
    // stimulus.
    // ########################################

    task automatic write_cfg(input cfg_target_t target, input int index, input int value);
        @(posedge clk);
        cfg <= '{write: 1'b1, target: target, index: 4'(index), value: 4'(value)};
        @(posedge clk);
        cfg <= '0;
        if (!model_locked) begin
            case (target)
                cfg_tile_op: if (index < num_tiles) m_op[index] = value;
                cfg_tile_src_a: if (index < num_tiles) m_src_a[index] = value;
                cfg_tile_src_b: if (index < num_tiles) m_src_b[index] = value;
                default: if (index < num_srcs) m_map[index] = value;
            endcase
        end
    endtask

    task automatic set_tile(input int t, input int op, input int src_a, input int src_b);
        write_cfg(cfg_tile_op, t, op);
        write_cfg(cfg_tile_src_a, t, src_a);
        write_cfg(cfg_tile_src_b, t, src_b);
    endtask

    task automatic set_lock(input logic on);
        @(posedge clk);
        lock <= on;
        unlock <= !on;
        @(posedge clk);
        lock <= 1'b0;
        unlock <= 1'b0;
        model_locked = on;
        @(negedge clk);
        expect_value("config_locked", int'(config_locked), int'(on));
    endtask

    task automatic send_request();
        logic got;
        @(posedge clk);
        issue <= '{new_request: 1'b1, id: next_id,
                   operands: {$urandom(), $urandom(), $urandom(), $urandom(), $urandom()}};
        do begin
            @(negedge clk);
            got = ready;
            @(posedge clk);
        end while (!got);
        issue <= '0;
        next_id = next_id + 1'b1;
    endtask

    // request held high, a new one after each acceptance.
    task automatic flood(input int cycles, output int count);
        logic got;
        count = 0;
        @(posedge clk);
        issue <= '{1'b1, next_id, {$urandom(), $urandom(), $urandom(), $urandom(), $urandom()}};
        repeat (cycles) begin
            @(negedge clk);
            got = ready;
            @(posedge clk);
            if (got) begin
                count++;
                next_id = next_id + 1'b1;
                issue <= '{1'b1, next_id,
                           {$urandom(), $urandom(), $urandom(), $urandom(), $urandom()}};
            end
        end
        issue <= '0;
    endtask

    task automatic check_latency();
        @(negedge clk);
        expect_value("done one cycle after accept", int'(done), 0);
        @(posedge clk);
        @(negedge clk);
        expect_value("done two cycles after accept", int'(done), 1);
    endtask

    task automatic finish_test(input string name);
        do @(negedge clk); while (exp_q.size() != 0 || done);
        if (errors == errors_seen) begin
            passes++;
            $display("test %s: ok", name);
        end else begin
            fails++;
            $display("test %s: %0d errors", name, errors - errors_seen);
        end
        errors_seen = errors;
    endtask

    initial begin
        void'($urandom(39));
        for (int t = 0; t < num_tiles; t++) begin
            m_op[t] = 0;
            m_src_a[t] = 0;
            m_src_b[t] = 1;
        end
        m_map = '{0, 0, 0, 0, 0};
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        expect_value("done", int'(done), 0);
        expect_value("ready", int'(ready), 0);
        expect_value("config_locked", int'(config_locked), 0);
        @(posedge clk);
        issue.new_request <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            expect_value("ready", int'(ready), 0);
        end
        @(posedge clk);
        issue <= '0;
        finish_test("reset");

        ack_mode = 1;
        for (int r = 0; r < 2; r++) begin
            for (int t = 0; t < num_tiles; t++) begin
                set_tile(t, 4 * r + t, t, t + 1);
            end
            for (int k = 0; k < num_srcs; k++) begin
                write_cfg(cfg_result_map, k, k % num_tiles);
            end
            set_lock(1'b1);
            send_request();
            check_latency();
            repeat (3) send_request();
            finish_test($sformatf("tile operations %0d", r));
            set_lock(1'b0);
        end

        // tile 0 reads zero as its previous output.
        set_tile(0, op_add, src_prev, src_rs1);
        set_tile(1, op_xor, src_prev, src_rs2);
        set_tile(2, op_sub, src_prev, src_rs3);
        set_tile(3, op_or, src_rs5, src_prev);
        set_lock(1'b1);
        repeat (4) send_request();
        finish_test("chaining");
        set_lock(1'b0);

        for (int t = 0; t < num_tiles; t++) begin
            set_tile(t, op_add, t, t + 1);
        end
        for (int k = 0; k < num_srcs; k++) begin
            write_cfg(cfg_result_map, k, (7 - k) % num_tiles);
        end
        set_lock(1'b1);
        repeat (4) send_request();
        finish_test("result mapping");

        set_tile(0, op_xor, src_rs5, src_rs5);
        write_cfg(cfg_result_map, 0, 1);
        repeat (3) send_request();
        set_lock(1'b0);
        set_tile(0, op_xor, src_rs5, src_rs4);
        write_cfg(cfg_result_map, 0, 0);
        set_lock(1'b1);
        repeat (3) send_request();
        finish_test("locking");

        ack_mode = 0;
        flood(10, accepted);
        expect_value("accepted requests", accepted, 4);
        @(negedge clk);
        expect_value("ready", int'(ready), 0);
        ack_mode = 2;
        repeat (8) send_request();
        finish_test("back-pressure");

        $display("tests passed %0d, failed %0d", passes, fails);
        if (fails == 0 && errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/rca_wrapper.sv ====
`timescale 1ns/1ps

module rca_wrapper #(
    parameter int num_tiles = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  rca_config_pkg::rca_cfg_write_t cfg,
    input  logic                           lock,
    input  logic                           unlock,
    output logic                           config_locked,
    input  rca_cpu_pkg::rca_issue_t        issue,
    output logic                           ready,
    output logic                           done,
    output rca_cpu_pkg::rca_wb_t           wb,
    input  logic                           ack
);

    import rca_cpu_pkg::*;
    import rca_config_pkg::*;

    rca_config_t                        config_img;
    logic                               new_request;
    logic                               accept;
    logic [num_tiles-1:0][xlen-1:0]     op_a;
    logic [num_tiles-1:0][xlen-1:0]     op_b;
    logic [num_tiles-1:0][xlen-1:0]     tile_out;
    logic                               rtr_valid;
    logic [id_width-1:0]                rtr_id;

    assign new_request = issue.new_request;

    rca_config_regs #(
        .num_tiles(num_tiles)
    ) i_config_regs (
        .clk,
        .rst_n,
        .cfg,
        .lock,
        .unlock,
        .config_img,
        .config_locked
    );

    rca_operand_router #(
        .num_tiles(num_tiles)
    ) i_router (
        .clk,
        .rst_n,
        .issue,
        .accept,
        .config_img,
        .tile_out,
        .op_a,
        .op_b,
        .valid(rtr_valid),
        .id(rtr_id)
    );

    // ########################################
    // tile row.
    // ########################################

    for (genvar t = 0; t < num_tiles; t++) begin : g_tile
        rca_tile i_tile (
            .op(config_img.tiles[t].op),
            .a(op_a[t]),
            .b(op_b[t]),
            .result(tile_out[t])
        );
    end

    rca_result_collector #(
        .num_tiles(num_tiles)
    ) i_collector (
        .clk,
        .rst_n,
        .tile_out,
        .valid(rtr_valid),
        .id(rtr_id),
        .config_img,
        .config_locked,
        .new_request,
        .accept,
        .ready,
        .done,
        .wb,
        .ack
    );

endmodule

// ==== hw/rca_result_collector.sv ====
`timescale 1ns/1ps

module rca_result_collector #(
    parameter int num_tiles = 4
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic [num_tiles-1:0][rca_cpu_pkg::xlen-1:0] tile_out,
    input  logic                                        valid,
    input  logic [rca_cpu_pkg::id_width-1:0]            id,
    input  rca_config_pkg::rca_config_t                 config_img,
    input  logic                                        config_locked,
    input  logic                                        new_request,
    output logic                                        accept,
    output logic                                        ready,
    output logic                                        done,
    output rca_cpu_pkg::rca_wb_t                        wb,
    input  logic                                        ack
);

    import rca_cpu_pkg::*;

    localparam int depth = 4;

    rca_wb_t    queue_mem [depth];
    rca_wb_t    entry;
    logic [1:0] wr_ptr;
    logic [1:0] rd_ptr;
    logic [2:0] count;
    logic [2:0] credits;
    logic       push;
    logic       pop;

    // ########################################
    // result mapping.
    // ########################################

    assign entry.id          = id;
    assign entry.results.rd1 = tile_out[config_img.result_map[0]];
    assign entry.results.rd2 = tile_out[config_img.result_map[1]];
    assign entry.results.rd3 = tile_out[config_img.result_map[2]];
    assign entry.results.rd4 = tile_out[config_img.result_map[3]];
    assign entry.results.rd5 = tile_out[config_img.result_map[4]];

    // ########################################
    // handshake.
    // ########################################

    // credits cover queued entries and requests still in the pipe.
    assign ready  = config_locked && (credits < 3'(depth));
    assign accept = new_request && ready;
    assign push   = valid;
    assign pop    = done && ack;
    assign done   = count != 3'd0;
    assign wb     = queue_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            queue_mem[wr_ptr] <= entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= 2'd0;
            rd_ptr  <= 2'd0;
            count   <= 3'd0;
            credits <= 3'd0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 2'd1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 2'd1;
            end
            case ({push, pop})
                2'b10:   count <= count + 3'd1;
                2'b01:   count <= count - 3'd1;
                default: count <= count;
            endcase
            case ({accept, pop})
                2'b10:   credits <= credits + 3'd1;
                2'b01:   credits <= credits - 3'd1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// ==== hw/rca_tile.sv ====
`timescale 1ns/1ps

module rca_tile (
    input  rca_config_pkg::tile_op_t     op,
    input  logic [rca_cpu_pkg::xlen-1:0] a,
    input  logic [rca_cpu_pkg::xlen-1:0] b,
    output logic [rca_cpu_pkg::xlen-1:0] result
);

    import rca_config_pkg::*;

    logic [4:0] shamt;

    // shift amount from low bits of b.
    assign shamt = b[4:0];

    // ########################################
    // operation select.
    // ########################################

    always_comb begin
        case (op)
            op_add: begin
                result = a + b;
            end
            op_sub: begin
                result = a - b;
            end
            op_and: begin
                result = a & b;
            end
            op_or: begin
                result = a | b;
            end
            op_xor: begin
                result = a ^ b;
            end
            op_sll: begin
                result = a << shamt;
            end
            op_srl: begin
                result = a >> shamt;
            end
            op_pass_a: begin
                result = a;
            end
            default: begin
                result = a;
            end
        endcase
    end

endmodule

// ==== hw/rca_operand_router.sv ====
`timescale 1ns/1ps

module rca_operand_router #(
    parameter int num_tiles = 4
) (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  rca_cpu_pkg::rca_issue_t                      issue,
    input  logic                                         accept,
    input  rca_config_pkg::rca_config_t                  config_img,
    input  logic [num_tiles-1:0][rca_cpu_pkg::xlen-1:0]  tile_out,
    output logic [num_tiles-1:0][rca_cpu_pkg::xlen-1:0]  op_a,
    output logic [num_tiles-1:0][rca_cpu_pkg::xlen-1:0]  op_b,
    output logic                                         valid,
    output logic [rca_cpu_pkg::id_width-1:0]             id
);

    import rca_cpu_pkg::*;
    import rca_config_pkg::*;

    rca_operands_t operands_q;
    logic          valid_q;

    function automatic logic [xlen-1:0] pick_src(
        input rca_operands_t   ops,
        input src_sel_t        sel,
        input logic [xlen-1:0] prev
    );
        logic [xlen-1:0] word;
        case (sel)
            src_rs1:  word = ops.rs1;
            src_rs2:  word = ops.rs2;
            src_rs3:  word = ops.rs3;
            src_rs4:  word = ops.rs4;
            src_rs5:  word = ops.rs5;
            src_prev: word = prev;
            default:  word = '0;
        endcase
        return word;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            operands_q <= issue.operands;
            id         <= issue.id;
        end
    end

    assign valid = valid_q;

    // chain settles through the row within the cycle.
    for (genvar t = 0; t < num_tiles; t++) begin : g_sel
        logic [xlen-1:0] prev;
        if (t == 0) begin : g_first
            assign prev = '0;
        end else begin : g_rest
            assign prev = tile_out[t-1];
        end
        assign op_a[t] = pick_src(operands_q, config_img.tiles[t].src_a, prev);
        assign op_b[t] = pick_src(operands_q, config_img.tiles[t].src_b, prev);
    end

endmodule

// ==== hw/rca_config_regs.sv ====
`timescale 1ns/1ps

module rca_config_regs #(
    parameter int num_tiles = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  rca_config_pkg::rca_cfg_write_t cfg,
    input  logic                          lock,
    input  logic                          unlock,
    output rca_config_pkg::rca_config_t   config_img,
    output logic                          config_locked
);

    import rca_cpu_pkg::*;
    import rca_config_pkg::*;

    rca_config_t cfg_q;
    rca_config_t cfg_next;
    logic        locked_q;
    logic        wr_en;
    logic        tile_hit;
    logic        map_hit;

    // ########################################
    // write decode.
    // ########################################

    assign wr_en = cfg.write && !locked_q;

    // out of range indices are dropped.
    assign tile_hit = int'(cfg.index) < num_tiles;
    assign map_hit  = (int'(cfg.index) < num_srcs) && (int'(cfg.value) < num_tiles);

    always_comb begin
        cfg_next = cfg_q;
        if (wr_en) begin
            case (cfg.target)
                cfg_tile_op: begin
                    if (tile_hit) begin
                        cfg_next.tiles[cfg.index[2:0]].op = tile_op_t'(cfg.value[2:0]);
                    end
                end
                cfg_tile_src_a: begin
                    if (tile_hit) begin
                        cfg_next.tiles[cfg.index[2:0]].src_a = src_sel_t'(cfg.value[2:0]);
                    end
                end
                cfg_tile_src_b: begin
                    if (tile_hit) begin
                        cfg_next.tiles[cfg.index[2:0]].src_b = src_sel_t'(cfg.value[2:0]);
                    end
                end
                cfg_result_map: begin
                    if (map_hit) begin
                        cfg_next.result_map[cfg.index[2:0]] = tile_idx_t'(cfg.value[2:0]);
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // ########################################
    // image and lock state.
    // ########################################

    // write sees the old lock, so it lands before a same-cycle lock.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q.tiles      <= {max_tiles{tile_cfg_reset}};
            cfg_q.result_map <= '0;
            locked_q         <= 1'b0;
        end else begin
            cfg_q <= cfg_next;
            if (lock) begin
                locked_q <= 1'b1;
            end else if (unlock) begin
                locked_q <= 1'b0;
            end
        end
    end

    assign config_img    = cfg_q;
    assign config_locked = locked_q;

endmodule

// ==== hw/rca_config_pkg.sv ====
package rca_config_pkg;

    // upper bound on the tile row.
    localparam int max_tiles = 8;

    // ########################################
    // tile operations and operand sources.
    // ########################################

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_srl,
        op_pass_a
    } tile_op_t;

    typedef logic [2:0] src_sel_t;

    localparam src_sel_t src_rs1 = 3'd0;
    localparam src_sel_t src_rs2 = 3'd1;
    localparam src_sel_t src_rs3 = 3'd2;
    localparam src_sel_t src_rs4 = 3'd3;
    localparam src_sel_t src_rs5 = 3'd4;
    // previous tile output, zero for tile 0.
    localparam src_sel_t src_prev = 3'd5;

    typedef logic [2:0] tile_idx_t;

    // ########################################
    // configuration writes and image.
    // ########################################

    typedef enum logic [1:0] {
        cfg_tile_op,
        cfg_tile_src_a,
        cfg_tile_src_b,
        cfg_result_map
    } cfg_target_t;

    typedef struct packed {
        logic        write;
        cfg_target_t target;
        logic [3:0]  index;
        logic [3:0]  value;
    } rca_cfg_write_t;

    typedef struct packed {
        tile_op_t op;
        src_sel_t src_a;
        src_sel_t src_b;
    } tile_cfg_t;

    typedef struct packed {
        tile_cfg_t [max_tiles-1:0]             tiles;
        tile_idx_t [rca_cpu_pkg::num_srcs-1:0] result_map;
    } rca_config_t;

    localparam tile_cfg_t tile_cfg_reset = '{op: op_add, src_a: src_rs1, src_b: src_rs2};

endpackage

// ==== hw/rca_cpu_pkg.sv ====
package rca_cpu_pkg;

    // ########################################
    // core-facing widths.
    // ########################################

    localparam int xlen = 32;
    localparam int id_width = 4;
    localparam int num_srcs = 5;

    // ########################################
    // issue and writeback bundles.
    // ########################################

    // rs1 sits in the upper bits.
    typedef struct packed {
        logic [xlen-1:0] rs1;
        logic [xlen-1:0] rs2;
        logic [xlen-1:0] rs3;
        logic [xlen-1:0] rs4;
        logic [xlen-1:0] rs5;
    } rca_operands_t;

    typedef struct packed {
        logic                new_request;
        logic [id_width-1:0] id;
        rca_operands_t       operands;
    } rca_issue_t;

    typedef struct packed {
        logic [xlen-1:0] rd1;
        logic [xlen-1:0] rd2;
        logic [xlen-1:0] rd3;
        logic [xlen-1:0] rd4;
        logic [xlen-1:0] rd5;
    } rca_results_t;

    // one queue entry, returned with done.
    typedef struct packed {
        logic [id_width-1:0] id;
        rca_results_t        results;
    } rca_wb_t;

endpackage
